/* hdl/xif_macros.svh */
// sizing and field positions of the coprocessor dispatch subsystem
// coprocessor and rule counts, instruction bit offsets, tag width

`ifndef XIF_MACROS_SVH
`define XIF_MACROS_SVH

// number of attached coprocessors
`define XIF_N_COPROC 2
// one rule per coprocessor, default one included
`define XIF_N_RULES 2
// signature slots per rule
`define XIF_N_SIGN 4
// receives instructions no rule claims
`define XIF_DEFAULT_IDX 1

// opcode and func3 placement in the instruction word
`define XIF_OPCODE_OFF 0
`define XIF_OPCODE_W 7
`define XIF_FUNC3_OFF 12
`define XIF_FUNC3_W 3

// signature is opcode followed by func3
`define XIF_SIGN_W 10

// instruction tag width
`define XIF_ID_W 4

`endif

/* hdl/xif_pkg.sv */
// extension interface types
// instruction word, operand/result word, tag and destination register

`include "xif_macros.svh"

package xif_pkg;

  // raw instruction as issued by the core
  typedef logic [31:0] instr_t;

  // source operand and result data
  typedef logic [31:0] operand_t;

  // tag carried from issue to result
  typedef logic [`XIF_ID_W-1:0] id_t;

  // destination register, instr[11:7]
  typedef logic [4:0] reg_addr_t;

endpackage

/* hdl/dispatch_pkg.sv */
// dispatch rule types and result stage state
// signature, coprocessor select, rule/slot indices, result FSM enum

`include "xif_macros.svh"

package dispatch_pkg;

  // {opcode, func3}
  typedef logic [`XIF_SIGN_W-1:0] sign_t;

  // one bit per coprocessor, one-hot after priority pick
  typedef logic [`XIF_N_COPROC-1:0] coproc_sel_t;

  // rule table addressing
  typedef logic rule_idx_t;
  typedef logic [1:0] slot_idx_t;

  // result holding register
  typedef enum logic {
    IDLE,
    HOLD
  } result_state_e;

endpackage

/* hdl/dispatch_rule_table.sv */
// signature rule register file
// one slot written per configuration strobe, all slots unused after reset

`timescale 1ns/1ns
`include "xif_macros.svh"

module dispatch_rule_table (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cfg_we_i,
  input  dispatch_pkg::rule_idx_t cfg_rule_i,
  input  dispatch_pkg::slot_idx_t cfg_slot_i,
  input  dispatch_pkg::sign_t     cfg_sign_i,
  output dispatch_pkg::sign_t [`XIF_N_RULES-1:0][`XIF_N_SIGN-1:0] rules_o
);

  import dispatch_pkg::*;

  // rule x slot storage
  sign_t [`XIF_N_RULES-1:0][`XIF_N_SIGN-1:0] rules_q;

  // all-ones marks a free slot, never matches a real signature
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rules_q <= '1;
    end else if (cfg_we_i) begin
      rules_q[cfg_rule_i][cfg_slot_i] <= cfg_sign_i;
    end
  end

  assign rules_o = rules_q;

  // writing the unused code would silently free the slot
  a_no_unused_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cfg_we_i |-> (cfg_sign_i != sign_t'('1))
  );

endmodule

/* hdl/xif_arith_coproc.sv */
// two-stage arithmetic coprocessor
// accepts func3 0..3: add, sub, mul low, xor; rejects the rest

`timescale 1ns/1ns
`include "xif_macros.svh"

module xif_arith_coproc (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  input  xif_pkg::instr_t    instr_i,
  input  xif_pkg::operand_t  rs1_i,
  input  xif_pkg::operand_t  rs2_i,
  input  xif_pkg::id_t       id_i,
  output logic               accept_o,
  output logic               writeback_o,
  output logic               result_valid_o,
  input  logic               result_ready_i,
  output xif_pkg::id_t       result_id_o,
  output xif_pkg::reg_addr_t result_rd_o,
  output xif_pkg::operand_t  result_data_o
);

  import xif_pkg::*;

  logic [`XIF_FUNC3_W-1:0] func3;
  logic                    issue_fire;
  logic                    s1_ready;
  logic                    s2_ready;

  // stage one, operands and op
  logic                    s1_valid_q;
  logic [1:0]              s1_op_q;
  operand_t                s1_a_q;
  operand_t                s1_b_q;
  id_t                     s1_id_q;
  reg_addr_t               s1_rd_q;
  operand_t                alu_res;

  // stage two, finished result
  logic                    s2_valid_q;
  id_t                     s2_id_q;
  reg_addr_t               s2_rd_q;
  operand_t                s2_data_q;

  assign func3 = instr_i[`XIF_FUNC3_OFF +: `XIF_FUNC3_W];

  // top func3 half is not ours
  assign accept_o    = issue_valid_i && (func3 < 3'd4);
  assign writeback_o = accept_o;

  // stall chain, ready falls only with both stages full and output blocked
  assign s2_ready      = !s2_valid_q || result_ready_i;
  assign s1_ready      = !s1_valid_q || s2_ready;
  assign issue_ready_o = s1_ready;

  // rejected instructions complete the handshake but leave no trace
  assign issue_fire = issue_valid_i & s1_ready & accept_o;

  always_comb begin
    case (s1_op_q)
      2'd0:    alu_res = s1_a_q + s1_b_q;
      2'd1:    alu_res = s1_a_q - s1_b_q;
      // low word of the product
      2'd2:    alu_res = s1_a_q * s1_b_q;
      default: alu_res = s1_a_q ^ s1_b_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= issue_fire;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      s1_op_q <= func3[1:0];
      s1_a_q  <= rs1_i;
      s1_b_q  <= rs2_i;
      s1_id_q <= id_i;
      // rd field sits at 11:7
      s1_rd_q <= instr_i[11:7];
    end
    if (s1_valid_q && s2_ready) begin
      s2_id_q   <= s1_id_q;
      s2_rd_q   <= s1_rd_q;
      s2_data_q <= alu_res;
    end
  end

  assign result_valid_o = s2_valid_q;
  assign result_id_o    = s2_id_q;
  assign result_rd_o    = s2_rd_q;
  assign result_data_o  = s2_data_q;

endmodule

/* hdl/xif_result_arbiter.sv */
// fixed-priority result merge
// lowest index wins, grant locked while the output is stalled

`timescale 1ns/1ns
`include "xif_macros.svh"

module xif_result_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`XIF_N_COPROC-1:0] cp_valid_i,
  input  xif_pkg::id_t             cp_id_i [`XIF_N_COPROC],
  input  xif_pkg::reg_addr_t       cp_rd_i [`XIF_N_COPROC],
  input  xif_pkg::operand_t        cp_data_i [`XIF_N_COPROC],
  output logic [`XIF_N_COPROC-1:0] cp_ready_o,
  output logic                     valid_o,
  output xif_pkg::id_t             id_o,
  output xif_pkg::reg_addr_t       rd_o,
  output xif_pkg::operand_t        data_o,
  input  logic                     ready_i
);

  import xif_pkg::*;
  import dispatch_pkg::*;

  coproc_sel_t pick;
  coproc_sel_t grant;
  coproc_sel_t grant_q;
  // last cycle ended with a stalled transfer
  logic        lock_q;

  // lowest-index valid
  always_comb begin
    pick = '0;
    for (int i = `XIF_N_COPROC - 1; i >= 0; i--) begin
      if (cp_valid_i[i]) begin
        pick    = '0;
        pick[i] = 1'b1;
      end
    end
  end

  // a stalled winner keeps the grant so the stream does not switch
  assign grant = lock_q ? grant_q : pick;

  always_comb begin
    valid_o = 1'b0;
    id_o    = '0;
    rd_o    = '0;
    data_o  = '0;
    for (int i = 0; i < `XIF_N_COPROC; i++) begin
      if (grant[i]) begin
        valid_o = cp_valid_i[i];
        id_o    = cp_id_i[i];
        rd_o    = cp_rd_i[i];
        data_o  = cp_data_i[i];
      end
    end
  end

  // losers see ready low and hold
  assign cp_ready_o = grant & {`XIF_N_COPROC{ready_i}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q  <= 1'b0;
      grant_q <= '0;
    end else begin
      lock_q  <= valid_o & ~ready_i;
      grant_q <= grant;
    end
  end

  a_grant_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i) |=> (valid_o && $stable(grant))
  );

endmodule

/* hdl/xif_inst_dispatcher.sv */
// instruction dispatcher
// signature match, priority select, issue routing, result holding stage

`timescale 1ns/1ns
`include "xif_macros.svh"

module xif_inst_dispatcher (
  input  logic               clk_i,
  input  logic               rst_ni,
  // core issue
  input  logic               issue_valid_i,
  input  xif_pkg::instr_t    issue_instr_i,
  input  xif_pkg::operand_t  issue_rs1_i,
  input  xif_pkg::operand_t  issue_rs2_i,
  input  xif_pkg::id_t       issue_id_i,
  output logic               issue_ready_o,
  output logic               issue_accept_o,
  output logic               issue_writeback_o,
  // rule table
  input  dispatch_pkg::sign_t [`XIF_N_RULES-1:0][`XIF_N_SIGN-1:0] rules_i,
  // coprocessor issue
  output logic [`XIF_N_COPROC-1:0] cp_issue_valid_o,
  output xif_pkg::instr_t    cp_instr_o [`XIF_N_COPROC],
  output xif_pkg::operand_t  cp_rs1_o [`XIF_N_COPROC],
  output xif_pkg::operand_t  cp_rs2_o [`XIF_N_COPROC],
  output xif_pkg::id_t       cp_id_o [`XIF_N_COPROC],
  input  logic [`XIF_N_COPROC-1:0] cp_issue_ready_i,
  input  logic [`XIF_N_COPROC-1:0] cp_accept_i,
  input  logic [`XIF_N_COPROC-1:0] cp_writeback_i,
  // merged results from the arbiter
  input  logic               arb_valid_i,
  input  xif_pkg::id_t       arb_id_i,
  input  xif_pkg::reg_addr_t arb_rd_i,
  input  xif_pkg::operand_t  arb_data_i,
  output logic               arb_ready_o,
  // core result
  output logic               result_valid_o,
  output xif_pkg::id_t       result_id_o,
  output xif_pkg::reg_addr_t result_rd_o,
  output xif_pkg::operand_t  result_data_o,
  input  logic               result_ready_i
);

  import xif_pkg::*;
  import dispatch_pkg::*;

  logic [`XIF_OPCODE_W-1:0] opcode;
  logic [`XIF_FUNC3_W-1:0]  func3;
  sign_t                    sign;
  // rule hits, then default fallback, then one-hot pick
  coproc_sel_t              match;
  coproc_sel_t              cand;
  coproc_sel_t              sel;

  result_state_e            state_q;
  result_state_e            state_d;
  logic                     load;
  id_t                      id_q;
  reg_addr_t                rd_q;
  operand_t                 data_q;

  // ====================================================================
  // signature detection and select
  // ====================================================================

  assign opcode = issue_instr_i[`XIF_OPCODE_OFF +: `XIF_OPCODE_W];
  assign func3  = issue_instr_i[`XIF_FUNC3_OFF +: `XIF_FUNC3_W];
  assign sign   = {opcode, func3};

  // rule r belongs to coprocessor r
  always_comb begin
    match = '0;
    for (int r = 0; r < `XIF_N_RULES; r++) begin
      for (int s = 0; s < `XIF_N_SIGN; s++) begin
        if (rules_i[r][s] == sign) begin
          match[r] = 1'b1;
        end
      end
    end
  end

  // nobody claims it -> default coprocessor
  assign cand = (match != '0) ? match : coproc_sel_t'(1) << `XIF_DEFAULT_IDX;

  // lowest index wins, scan downwards so it is written last
  always_comb begin
    sel = '0;
    for (int i = `XIF_N_COPROC - 1; i >= 0; i--) begin
      if (cand[i]) begin
        sel    = '0;
        sel[i] = 1'b1;
      end
    end
  end

  // ====================================================================
  // issue routing
  // ====================================================================

  // unselected coprocessors see an all-zero request
  always_comb begin
    issue_ready_o     = 1'b0;
    issue_accept_o    = 1'b0;
    issue_writeback_o = 1'b0;
    for (int i = 0; i < `XIF_N_COPROC; i++) begin
      cp_issue_valid_o[i] = sel[i] & issue_valid_i;
      cp_instr_o[i]       = sel[i] ? issue_instr_i : '0;
      cp_rs1_o[i]         = sel[i] ? issue_rs1_i : '0;
      cp_rs2_o[i]         = sel[i] ? issue_rs2_i : '0;
      cp_id_o[i]          = sel[i] ? issue_id_i : '0;
      // response comes back only from the selected one
      if (sel[i]) begin
        issue_ready_o     = cp_issue_ready_i[i];
        issue_accept_o    = cp_accept_i[i];
        issue_writeback_o = cp_writeback_i[i];
      end
    end
  end

  // ====================================================================
  // result holding stage
  // ====================================================================

  // HOLD refills straight from the arbiter when the core drains it
  always_comb begin
    state_d     = state_q;
    arb_ready_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        arb_ready_o = 1'b1;
        if (arb_valid_i) begin
          state_d = HOLD;
        end
      end
      HOLD: begin
        arb_ready_o = result_ready_i;
        if (result_ready_i && !arb_valid_i) begin
          state_d = IDLE;
        end
      end
    endcase
  end

  assign load = arb_valid_i & arb_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // payload only
  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q   <= arb_id_i;
      rd_q   <= arb_rd_i;
      data_q <= arb_data_i;
    end
  end

  assign result_valid_o = (state_q == HOLD);
  assign result_id_o    = id_q;
  assign result_rd_o    = rd_q;
  assign result_data_o  = data_q;

  a_sel_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i |-> $onehot(sel)
  );

  // core must see the same result until it takes it
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (result_valid_o && !result_ready_i) |=>
      (result_valid_o && $stable(result_data_o) && $stable(result_id_o))
  );

endmodule

/* hdl/xif_dispatch_top.sv */
// coprocessor dispatch subsystem top level
// rule table, dispatcher, two arithmetic coprocessors, result arbiter

`timescale 1ns/1ns
`include "xif_macros.svh"

module xif_dispatch_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // rule configuration
  input  logic                    cfg_we_i,
  input  dispatch_pkg::rule_idx_t cfg_rule_i,
  input  dispatch_pkg::slot_idx_t cfg_slot_i,
  input  dispatch_pkg::sign_t     cfg_sign_i,
  // issue
  input  logic                    issue_valid_i,
  input  xif_pkg::instr_t         issue_instr_i,
  input  xif_pkg::operand_t       issue_rs1_i,
  input  xif_pkg::operand_t       issue_rs2_i,
  input  xif_pkg::id_t            issue_id_i,
  output logic                    issue_ready_o,
  output logic                    issue_accept_o,
  output logic                    issue_writeback_o,
  // result
  output logic                    result_valid_o,
  output xif_pkg::id_t            result_id_o,
  output xif_pkg::reg_addr_t      result_rd_o,
  output xif_pkg::operand_t       result_data_o,
  input  logic                    result_ready_i
);

  import xif_pkg::*;
  import dispatch_pkg::*;

  sign_t [`XIF_N_RULES-1:0][`XIF_N_SIGN-1:0] rules;

  // dispatcher -> coprocessors
  logic [`XIF_N_COPROC-1:0] cp_issue_valid;
  instr_t                   cp_instr [`XIF_N_COPROC];
  operand_t                 cp_rs1 [`XIF_N_COPROC];
  operand_t                 cp_rs2 [`XIF_N_COPROC];
  id_t                      cp_id [`XIF_N_COPROC];
  logic [`XIF_N_COPROC-1:0] cp_issue_ready;
  logic [`XIF_N_COPROC-1:0] cp_accept;
  logic [`XIF_N_COPROC-1:0] cp_writeback;

  // coprocessors -> arbiter
  logic [`XIF_N_COPROC-1:0] cp_res_valid;
  id_t                      cp_res_id [`XIF_N_COPROC];
  reg_addr_t                cp_res_rd [`XIF_N_COPROC];
  operand_t                 cp_res_data [`XIF_N_COPROC];
  logic [`XIF_N_COPROC-1:0] cp_res_ready;

  // arbiter -> holding stage
  logic                     arb_valid;
  id_t                      arb_id;
  reg_addr_t                arb_rd;
  operand_t                 arb_data;
  logic                     arb_ready;

  dispatch_rule_table i_dispatch_rule_table (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_we_i   (cfg_we_i),
    .cfg_rule_i (cfg_rule_i),
    .cfg_slot_i (cfg_slot_i),
    .cfg_sign_i (cfg_sign_i),
    .rules_o    (rules)
  );

  xif_inst_dispatcher i_xif_inst_dispatcher (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .issue_valid_i     (issue_valid_i),
    .issue_instr_i     (issue_instr_i),
    .issue_rs1_i       (issue_rs1_i),
    .issue_rs2_i       (issue_rs2_i),
    .issue_id_i        (issue_id_i),
    .issue_ready_o     (issue_ready_o),
    .issue_accept_o    (issue_accept_o),
    .issue_writeback_o (issue_writeback_o),
    .rules_i           (rules),
    .cp_issue_valid_o  (cp_issue_valid),
    .cp_instr_o        (cp_instr),
    .cp_rs1_o          (cp_rs1),
    .cp_rs2_o          (cp_rs2),
    .cp_id_o           (cp_id),
    .cp_issue_ready_i  (cp_issue_ready),
    .cp_accept_i       (cp_accept),
    .cp_writeback_i    (cp_writeback),
    .arb_valid_i       (arb_valid),
    .arb_id_i          (arb_id),
    .arb_rd_i          (arb_rd),
    .arb_data_i        (arb_data),
    .arb_ready_o       (arb_ready),
    .result_valid_o    (result_valid_o),
    .result_id_o       (result_id_o),
    .result_rd_o       (result_rd_o),
    .result_data_o     (result_data_o),
    .result_ready_i    (result_ready_i)
  );

  // identical coprocessors, index 0 has result priority
  for (genvar i = 0; i < `XIF_N_COPROC; i++) begin : g_coproc
    xif_arith_coproc i_xif_arith_coproc (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .issue_valid_i  (cp_issue_valid[i]),
      .issue_ready_o  (cp_issue_ready[i]),
      .instr_i        (cp_instr[i]),
      .rs1_i          (cp_rs1[i]),
      .rs2_i          (cp_rs2[i]),
      .id_i           (cp_id[i]),
      .accept_o       (cp_accept[i]),
      .writeback_o    (cp_writeback[i]),
      .result_valid_o (cp_res_valid[i]),
      .result_ready_i (cp_res_ready[i]),
      .result_id_o    (cp_res_id[i]),
      .result_rd_o    (cp_res_rd[i]),
      .result_data_o  (cp_res_data[i])
    );
  end

  xif_result_arbiter i_xif_result_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cp_valid_i (cp_res_valid),
    .cp_id_i    (cp_res_id),
    .cp_rd_i    (cp_res_rd),
    .cp_data_i  (cp_res_data),
    .cp_ready_o (cp_res_ready),
    .valid_o    (arb_valid),
    .id_o       (arb_id),
    .rd_o       (arb_rd),
    .data_o     (arb_data),
    .ready_i    (arb_ready)
  );

endmodule

/* verif/tb_xif_dispatch.sv */
// self-checking testbench for the coprocessor dispatch subsystem
// reference routing and arithmetic model, expected queue per coprocessor,
// result comparator, ready toggler and watchdog

`timescale 1ns/1ns
`include "xif_macros.svh"

module tb_xif_dispatch;

  import xif_pkg::*;
  import dispatch_pkg::*;

  localparam int N_DIRECTED  = 19;
  localparam int N_RANDOM    = 80;
  localparam int TIMEOUT_CYC = 20 * (N_DIRECTED + N_RANDOM) + 1000;
  // longest wait for outstanding results before a test ends
  localparam int DRAIN_CYC   = 50;

  // custom-0..3 opcodes, none of them forms the all-ones signature
  localparam logic [6:0] OP_C0 = 7'h0b;
  localparam logic [6:0] OP_C1 = 7'h2b;
  localparam logic [6:0] OP_C2 = 7'h5b;
  localparam logic [6:0] OP_C3 = 7'h7b;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      cfg_we_i;
  rule_idx_t cfg_rule_i;
  slot_idx_t cfg_slot_i;
  sign_t     cfg_sign_i;
  logic      issue_valid_i;
  instr_t    issue_instr_i;
  operand_t  issue_rs1_i;
  operand_t  issue_rs2_i;
  id_t       issue_id_i;
  logic      issue_ready_o;
  logic      issue_accept_o;
  logic      issue_writeback_o;
  logic      result_valid_o;
  id_t       result_id_o;
  reg_addr_t result_rd_o;
  operand_t  result_data_o;
  logic      result_ready_i;

  // mirror of the rule table, written together with the DUT
  sign_t       tb_rules [2][4];
  // {id, rd, data} per coprocessor, in issue order
  logic [40:0] exp_q0 [$];
  logic [40:0] exp_q1 [$];
  logic        route_of_id [16];
  id_t         next_id;
  int          err_count;
  int          chk_count;
  int          test_errs;
  logic        ready_random;

  xif_dispatch_top i_xif_dispatch_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cfg_we_i          (cfg_we_i),
    .cfg_rule_i        (cfg_rule_i),
    .cfg_slot_i        (cfg_slot_i),
    .cfg_sign_i        (cfg_sign_i),
    .issue_valid_i     (issue_valid_i),
    .issue_instr_i     (issue_instr_i),
    .issue_rs1_i       (issue_rs1_i),
    .issue_rs2_i       (issue_rs2_i),
    .issue_id_i        (issue_id_i),
    .issue_ready_o     (issue_ready_o),
    .issue_accept_o    (issue_accept_o),
    .issue_writeback_o (issue_writeback_o),
    .result_valid_o    (result_valid_o),
    .result_id_o       (result_id_o),
    .result_rd_o       (result_rd_o),
    .result_data_o     (result_data_o),
    .result_ready_i    (result_ready_i)
  );

  always #5 clk_i = ~clk_i;

  // ====================================================================
  // reference model and helpers
  // ====================================================================

  // {route, accept, data}
  function automatic logic [33:0] model_instr(instr_t instr, operand_t a, operand_t b);
    logic [9:0] sign;
    logic [1:0] hit;
    logic       route;
    logic       acc;
    operand_t   res;
    sign = {instr[6:0], instr[14:12]};
    hit  = 2'b00;
    for (int r = 0; r < 2; r++) begin
      for (int s = 0; s < 4; s++) begin
        if (tb_rules[r][s] == sign) begin
          hit[r] = 1'b1;
        end
      end
    end
    // unclaimed goes to default, otherwise lowest rule
    if (hit == 2'b00) begin
      route = 1'(`XIF_DEFAULT_IDX);
    end else begin
      route = hit[0] ? 1'b0 : 1'b1;
    end
    acc = (instr[14] == 1'b0);
    case (instr[13:12])
      2'd0:    res = a + b;
      2'd1:    res = a - b;
      2'd2:    res = a * b;
      default: res = a ^ b;
    endcase
    return {route, acc, res};
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    chk_count++;
    if (actual !== expected) begin
      err_count++;
      $display("error: %s got 0x%0h expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic write_rule(input rule_idx_t r, input slot_idx_t s, input sign_t sg);
    cfg_we_i   = 1'b1;
    cfg_rule_i = r;
    cfg_slot_i = s;
    cfg_sign_i = sg;
    tb_rules[r][s] = sg;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
  endtask

  // called 1 ns after a rising edge, returns at the same offset
  task automatic issue_one(input logic [6:0] op, input logic [2:0] f3, input logic [4:0] rd);
    logic [31:0] hi;
    instr_t      instr;
    operand_t    a;
    operand_t    b;
    id_t         id;
    logic [33:0] m;
    hi      = $urandom;
    instr   = {hi[31:15], f3, rd, op};
    a       = $urandom;
    b       = $urandom;
    id      = next_id;
    next_id = next_id + 1'b1;
    m       = model_instr(instr, a, b);
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_rs1_i   = a;
    issue_rs2_i   = b;
    issue_id_i    = id;
    // sampled mid-cycle, transfer happens on the next rising edge
    @(negedge clk_i);
    while (!issue_ready_o) begin
      @(negedge clk_i);
    end
    check_value("issue_accept_o", issue_accept_o, m[32]);
    check_value("issue_writeback_o", issue_writeback_o, m[32]);
    check_value("cp_issue_valid", i_xif_dispatch_top.cp_issue_valid, 2'b01 << m[33]);
    if (m[32]) begin
      route_of_id[id] = m[33];
      if (m[33]) begin
        exp_q1.push_back({id, rd, m[31:0]});
      end else begin
        exp_q0.push_back({id, rd, m[31:0]});
      end
    end
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
  endtask

  // all results back within a bound, then a quiet window for stray ones
  task automatic drain_results();
    int waited;
    waited = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < DRAIN_CYC) begin
      @(negedge clk_i);
      waited++;
    end
    repeat (8) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic end_test(input int num, input string name);
    if (err_count == test_errs) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, err_count - test_errs);
    end
    test_errs = err_count;
  endtask

  // ====================================================================
  // result comparator, ready toggler, watchdog
  // ====================================================================

  always @(negedge clk_i) begin : compare_results
    logic [40:0] expd;
    logic        have;
    logic        cp;
    if (rst_ni && result_valid_o && result_ready_i) begin
      have = 1'b0;
      cp   = route_of_id[result_id_o];
      if (!cp && exp_q0.size() > 0) begin
        expd = exp_q0.pop_front();
        have = 1'b1;
      end else if (cp && exp_q1.size() > 0) begin
        expd = exp_q1.pop_front();
        have = 1'b1;
      end
      if (have) begin
        check_value("result_id_o", result_id_o, expd[40:37]);
        check_value("result_rd_o", result_rd_o, expd[36:32]);
        check_value("result_data_o", result_data_o, expd[31:0]);
      end else begin
        err_count++;
        $display("result with id %0h arrived while nothing was pending on coprocessor %0d",
                 result_id_o, cp);
      end
    end
  end

  always begin
    @(posedge clk_i);
    #1;
    if (ready_random) begin
      result_ready_i = $urandom_range(0, 1);
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("Simulation FAILED");
    $finish;
  end

  // ====================================================================
  // test sequence
  // ====================================================================

  initial begin : run_tests
    int lat;
    logic [6:0] ops [4];
    void'($urandom(32'hdfdd_9292));
    ops = '{OP_C0, OP_C1, OP_C2, OP_C3};
    rst_ni         = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_rule_i     = '0;
    cfg_slot_i     = '0;
    cfg_sign_i     = '0;
    issue_valid_i  = 1'b0;
    issue_instr_i  = '0;
    issue_rs1_i    = '0;
    issue_rs2_i    = '0;
    issue_id_i     = '0;
    result_ready_i = 1'b1;
    ready_random   = 1'b0;
    next_id        = '0;
    err_count      = 0;
    chk_count      = 0;
    test_errs      = 0;
    for (int i = 0; i < 16; i++) begin
      route_of_id[i] = 1'b0;
    end
    for (int r = 0; r < 2; r++) begin
      for (int s = 0; s < 4; s++) begin
        tb_rules[r][s] = '1;
      end
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // empty table, everything to the default coprocessor
    check_value("issue_ready_o", issue_ready_o, 1'b1);
    check_value("result_valid_o", result_valid_o, 1'b0);
    for (int f = 0; f < 8; f++) begin
      issue_one(OP_C0, 3'(f), 5'(f + 5));
    end
    drain_results();
    end_test(1, "default routing");

    // rule 0 claims four signatures, interleaved with unmatched ones
    write_rule(1'b0, 2'd0, {OP_C0, 3'd0});
    write_rule(1'b0, 2'd1, {OP_C0, 3'd2});
    write_rule(1'b0, 2'd2, {OP_C1, 3'd1});
    write_rule(1'b0, 2'd3, {OP_C1, 3'd3});
    issue_one(OP_C0, 3'd0, 5'd1);
    issue_one(OP_C0, 3'd1, 5'd2);
    issue_one(OP_C0, 3'd2, 5'd3);
    issue_one(OP_C0, 3'd3, 5'd4);
    issue_one(OP_C1, 3'd1, 5'd5);
    issue_one(OP_C1, 3'd0, 5'd6);
    issue_one(OP_C1, 3'd3, 5'd7);
    issue_one(OP_C2, 3'd2, 5'd8);
    drain_results();
    end_test(2, "programmed routing");

    // shared signature resolves to the lower index
    write_rule(1'b1, 2'd0, {OP_C0, 3'd0});
    write_rule(1'b1, 2'd1, {OP_C2, 3'd1});
    issue_one(OP_C0, 3'd0, 5'd9);
    issue_one(OP_C2, 3'd1, 5'd10);
    drain_results();
    end_test(3, "rule priority");

    // isolated instruction, count cycles up to result_valid_o
    issue_one(OP_C3, 3'd2, 5'd11);
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!result_valid_o && lat < 20);
    check_value("result latency", lat, 3);
    drain_results();
    end_test(4, "result latency");

    // random traffic against random back-pressure
    ready_random = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk_i);
        #1;
      end
      issue_one(ops[$urandom_range(0, 3)], 3'($urandom_range(0, 7)),
                5'($urandom_range(0, 31)));
    end
    ready_random = 1'b0;
    @(posedge clk_i);
    #1;
    result_ready_i = 1'b1;
    drain_results();
    check_value("pending results cp0", exp_q0.size(), 0);
    check_value("pending results cp1", exp_q1.size(), 0);
    end_test(5, "random traffic");

    $display("closing count: %0d checks, %0d errors", chk_count, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+hdl
hdl/xif_pkg.sv
hdl/dispatch_pkg.sv
hdl/dispatch_rule_table.sv
hdl/xif_arith_coproc.sv
hdl/xif_result_arbiter.sv
hdl/xif_inst_dispatcher.sv
hdl/xif_dispatch_top.sv
verif/tb_xif_dispatch.sv
